//--- tests/zxuno_io_patterns.txt
// op addr data cpu_din dev_options, values in hex
// op is W write, R read, A interrupt acknowledge
// Address register
R FC3B 00 00 00
W FC3B 0E FF 00
R FC3B 00 0E 00
// Device options
R FD3B 00 00 00
W FD3B 3C FF 3C
R FD3B 00 3C 3C
// Scratch
W FC3B FE FF 3C
R FD3B 00 00 3C
W FD3B 5A FF 3C
R FD3B 00 5A 3C
// Core ID text
W FC3B FF FF 3C
R FD3B 00 45 3C
R FD3B 00 58 3C
R FD3B 00 50 3C
R FD3B 00 32 3C
R FD3B 00 36 3C
R FD3B 00 2D 3C
R FD3B 00 30 3C
R FD3B 00 31 3C
R FD3B 00 00 3C
R FD3B 00 00 3C
// Restart of the text
W FC3B FF FF 3C
R FD3B 00 45 3C
R FD3B 00 58 3C
W FC3B FF FF 3C
R FD3B 00 45 3C
// Interrupt acknowledge and unmapped reads
A FC3B 00 FF 3C
W FC3B 55 FF 3C
R FD3B 00 FF 3C
R 00FE 00 FF 3C
W FC3B FE FF 3C
R FD3B 00 5A 3C

//--- sim.f
+incdir+src
src/bus_pkg.sv
src/dev_pkg.sv
src/zxuno_reg_port.sv
src/core_id_reader.sv
src/cfg_register.sv
src/bus_read_arbiter.sv
src/zxuno_io_top.sv
tests/tb_zxuno_io.sv

//--- Bender.yml
package:
  name: zxuno_io

sources:
  - include_dirs:
      - src
    files:
      - src/bus_pkg.sv
      - src/dev_pkg.sv
      - src/zxuno_reg_port.sv
      - src/core_id_reader.sv
      - src/cfg_register.sv
      - src/bus_read_arbiter.sv
      - src/zxuno_io_top.sv
  - target: test
    files:
      - tests/tb_zxuno_io.sv

//--- tests/tb_zxuno_io.sv
`timescale 1ns/1ns
`default_nettype none

module tb_zxuno_io
  import bus_pkg::*;
  import dev_pkg::*;
();

  localparam string PATTERN_FILE = "tests/zxuno_io_patterns.txt";
  localparam int    CLK_PERIOD   = 10;
  localparam int    RESET_CYCLES = 16;
  // Worst case per operation: two bus cycles, one release cycle, three idle
  localparam int    OP_CYCLES    = 6;

  logic         sysclk;
  logic         arst_n;
  io_bus_t      bus;
  logic [7:0]   cpu_din;
  dev_options_t dev_options;

  // Operations read from the pattern file
  logic [7:0]  op_q[$];
  logic [15:0] addr_q[$];
  logic [7:0]  data_q[$];
  logic [7:0]  din_q[$];
  logic [7:0]  opt_q[$];
  int          line_q[$];
  int          file_lines;
  bit          ops_loaded;

  zxuno_io_top dut0 (
    .sysclk      (sysclk),
    .arst_n      (arst_n),
    .bus         (bus),
    .cpu_din     (cpu_din),
    .dev_options (dev_options)
  );

  initial sysclk = 1'b0;
  always #(CLK_PERIOD / 2) sysclk = ~sysclk;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  function automatic io_bus_t idle_bus();
    io_bus_t b;
    b        = '0;
    b.iorq_n = 1'b1;
    b.rd_n   = 1'b1;
    b.wr_n   = 1'b1;
    b.m1_n   = 1'b1;
    return b;
  endfunction

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %02h actual %02h", name, expected, actual);
      $display("test failed");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    int          bad_line;
    string       line;
    logic [7:0]  op;
    logic [15:0] addr;
    logic [7:0]  data;
    logic [7:0]  exp_din;
    logic [7:0]  exp_opt;
    bad_line = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the pattern file %s", PATTERN_FILE);
      $display("test failed");
      $fatal(1, "pattern file missing");
    end else begin
      while (!$feof(fd) && bad_line == 0) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          file_lines++;
          // Comment and blank lines carry no operation
          if (line.len() > 2 && line[0] != "/") begin
            n = $sscanf(line, "%c %h %h %h %h", op, addr, data, exp_din, exp_opt);
            if (n != 5 || (op != "W" && op != "R" && op != "A")) begin
              bad_line = file_lines;
            end else begin
              op_q.push_back(op);
              addr_q.push_back(addr);
              data_q.push_back(data);
              din_q.push_back(exp_din);
              opt_q.push_back(exp_opt);
              line_q.push_back(file_lines);
            end
          end
        end
      end
      $fclose(fd);
      if (bad_line != 0) begin
        $display("line %0d of the pattern file could not be parsed", bad_line);
        $display("test failed");
        $fatal(1, "bad pattern file");
      end
    end
  endtask

  // One bus operation, two cycles long, then the bus goes idle
  task automatic run_op(input int i);
    io_bus_t b;
    string   name;
    b        = idle_bus();
    b.addr   = addr_q[i];
    b.dout   = data_q[i];
    b.iorq_n = 1'b0;
    case (op_q[i])
      "W": b.wr_n = 1'b0;
      "R": b.rd_n = 1'b0;
      default: begin
        // Interrupt acknowledge, with a read decoded at the same time
        b.rd_n = 1'b0;
        b.m1_n = 1'b0;
      end
    endcase
    name = $sformatf("line%0d_%c_%04h", line_q[i], op_q[i], addr_q[i]);
    @(negedge sysclk);
    bus = b;
    @(negedge sysclk);
    check_value({name, "_cpu_din"}, din_q[i], cpu_din);
    check_value({name, "_dev_options"}, opt_q[i], dev_options);
    @(negedge sysclk);
    bus = idle_bus();
  endtask

  // ------------------------------------------------------------
  // Stimulus and watchdog
  // ------------------------------------------------------------

  initial begin : stimulus
    int gap;
    void'($urandom(57));
    arst_n = 1'b0;
    bus    = idle_bus();
    load_patterns();
    ops_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge sysclk);
    @(negedge sysclk);
    arst_n = 1'b1;
    for (int i = 0; i < op_q.size(); i++) begin
      gap = $urandom % 4;
      repeat (gap) @(negedge sysclk);
      run_op(i);
    end
    $display("test passed");
    $finish;
  end

  initial begin : watchdog
    longint limit_ns;
    wait (ops_loaded);
    limit_ns = longint'(file_lines) * OP_CYCLES * CLK_PERIOD
             + RESET_CYCLES * CLK_PERIOD;
    #(limit_ns);
    $display("timeout, the operations did not finish within %0d ns", limit_ns);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- src/zxuno_io_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "zxuno_params.svh"

module zxuno_io_top
  import bus_pkg::*;
  import dev_pkg::*;
(
  input  logic         sysclk,
  input  logic         arst_n,
  input  io_bus_t      bus,
  output logic [7:0]   cpu_din,
  output dev_options_t dev_options
);

  reg_access_t access;
  rd_resp_t    regaddr_resp;
  rd_resp_t    coreid_resp;
  rd_resp_t    scratch_resp;
  rd_resp_t    devopt_resp;

  // ------------------------------------------------------------
  // Address and data port decode
  // ------------------------------------------------------------

  zxuno_reg_port u_reg_port (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .bus    (bus),
    .access (access),
    .resp   (regaddr_resp)
  );

  // ------------------------------------------------------------
  // Register peripherals
  // ------------------------------------------------------------

  core_id_reader u_core_id (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .access (access),
    .resp   (coreid_resp)
  );

  // Scratch value is only seen through readback
  cfg_register #(
    .payload_t (logic [7:0]),
    .REG_NUM   (`ZX_REG_SCRATCH)
  ) u_scratch (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .access (access),
    .din    (bus.dout),
    .value  (),
    .resp   (scratch_resp)
  );

  cfg_register #(
    .payload_t (dev_options_t),
    .REG_NUM   (`ZX_REG_DEVOPTIONS)
  ) u_devoptions (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .access (access),
    .din    (bus.dout),
    .value  (dev_options),
    .resp   (devopt_resp)
  );

  // ------------------------------------------------------------
  // CPU read bus
  // ------------------------------------------------------------

  bus_read_arbiter u_rd_arb (
    .bus          (bus),
    .regaddr_resp (regaddr_resp),
    .coreid_resp  (coreid_resp),
    .scratch_resp (scratch_resp),
    .devopt_resp  (devopt_resp),
    .cpu_din      (cpu_din)
  );

endmodule

`default_nettype wire

//--- src/bus_read_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "zxuno_params.svh"

module bus_read_arbiter
  import bus_pkg::*;
(
  input  io_bus_t    bus,
  input  rd_resp_t   regaddr_resp,
  input  rd_resp_t   coreid_resp,
  input  rd_resp_t   scratch_resp,
  input  rd_resp_t   devopt_resp,
  output logic [7:0] cpu_din
);

  logic intack;

  // IORQ together with M1 is an interrupt acknowledge
  assign intack = ~bus.iorq_n & ~bus.m1_n;

  // ------------------------------------------------------------
  // Fixed priority select
  // ------------------------------------------------------------

  always_comb begin
    if (intack) begin
      // IM2 vector is the floating bus value
      cpu_din = `ZX_BUS_IDLE;
    end else if (regaddr_resp.oe) begin
      cpu_din = regaddr_resp.data;
    end else if (coreid_resp.oe) begin
      cpu_din = coreid_resp.data;
    end else if (scratch_resp.oe) begin
      cpu_din = scratch_resp.data;
    end else if (devopt_resp.oe) begin
      cpu_din = devopt_resp.data;
    end else begin
      cpu_din = `ZX_BUS_IDLE;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Register numbers and ports must not overlap between peers
  always_comb begin
    a_single_oe : assert final ($onehot0({regaddr_resp.oe, coreid_resp.oe,
                                          scratch_resp.oe, devopt_resp.oe}));
  end

endmodule

`default_nettype wire

//--- src/cfg_register.sv
`timescale 1ns/1ns
`default_nettype none

module cfg_register
  import bus_pkg::*;
#(
  parameter type        payload_t = logic [7:0],
  parameter logic [7:0] REG_NUM   = 8'h00
) (
  input  logic        sysclk,
  input  logic        arst_n,
  input  reg_access_t access,
  input  logic [7:0]  din,
  output payload_t    value,
  output rd_resp_t    resp
);

  logic sel;

  // Payload has to fit the 8 bit data port
  if ($bits(payload_t) != 8) begin : g_width_check
    $error("cfg_register payload must be 8 bits wide");
  end

  assign sel = (access.addr == REG_NUM);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      value <= '0;
    end else if (access.wr && sel) begin
      value <= payload_t'(din);
    end
  end

  // ------------------------------------------------------------
  // Readback
  // ------------------------------------------------------------

  assign resp.data = value;
  assign resp.oe   = access.rd & sel;

endmodule

`default_nettype wire

//--- src/core_id_reader.sv
`timescale 1ns/1ns
`default_nettype none

`include "zxuno_params.svh"

module core_id_reader
  import bus_pkg::*;
  import dev_pkg::*;
(
  input  logic        sysclk,
  input  logic        arst_n,
  input  reg_access_t access,
  output rd_resp_t    resp
);

  localparam int IDX_W = $clog2(`ZX_COREID_LEN + 1);

  logic [IDX_W-1:0] idx;
  logic             rd_q;
  logic             sel;
  logic             rd_done;

  assign sel = (access.addr == `ZX_REG_COREID);

  // Read has just ended, rd falling
  assign rd_done = rd_q & ~access.rd & sel;

  // ------------------------------------------------------------
  // Character index
  // ------------------------------------------------------------

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      idx  <= '0;
      rd_q <= 1'b0;
    end else begin
      rd_q <= access.rd;
      if (access.addr_changed) begin
        idx <= '0;
      end else if (rd_done && idx != IDX_W'(`ZX_COREID_LEN)) begin
        // Stops one past the last character
        idx <= idx + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Read response
  // ------------------------------------------------------------

  always_comb begin
    if (idx < IDX_W'(`ZX_COREID_LEN)) begin
      resp.data = COREID_TEXT[idx];
    end else begin
      // End of text marker
      resp.data = 8'h00;
    end
  end

  assign resp.oe = access.rd & sel;

endmodule

`default_nettype wire

//--- src/zxuno_reg_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "zxuno_params.svh"

module zxuno_reg_port
  import bus_pkg::*;
(
  input  logic        sysclk,
  input  logic        arst_n,
  input  io_bus_t     bus,
  output reg_access_t access,
  output rd_resp_t    resp
);

  logic       io_rd;
  logic       io_wr;
  logic       sel_regaddr;
  logic       sel_regdata;
  logic       addr_wr;
  logic       addr_wr_q;
  logic       addr_changed_q;
  logic [7:0] reg_addr;

  // ------------------------------------------------------------
  // Port decode, full 16 bit match
  // ------------------------------------------------------------

  assign io_rd       = ~bus.iorq_n & ~bus.rd_n;
  assign io_wr       = ~bus.iorq_n & ~bus.wr_n;
  assign sel_regaddr = (bus.addr == `ZX_PORT_REGADDR);
  assign sel_regdata = (bus.addr == `ZX_PORT_REGDATA);
  assign addr_wr     = io_wr & sel_regaddr;

  // ------------------------------------------------------------
  // Register number latch
  // ------------------------------------------------------------

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      reg_addr       <= 8'h00;
      addr_wr_q      <= 1'b0;
      addr_changed_q <= 1'b0;
    end else begin
      addr_wr_q <= addr_wr;
      // Pulse only on the first edge of a write, OUTs last several clocks
      addr_changed_q <= addr_wr & ~addr_wr_q;
      if (addr_wr) begin
        reg_addr <= bus.dout;
      end
    end
  end

  // Strobes towards the register peripherals
  assign access.addr         = reg_addr;
  assign access.rd           = io_rd & sel_regdata;
  assign access.wr           = io_wr & sel_regdata;
  assign access.addr_changed = addr_changed_q;

  // Readback of the register number
  assign resp.data = reg_addr;
  assign resp.oe   = io_rd & sel_regaddr;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // A bus master never reads and writes the data port at once
  a_no_rd_wr : assert property (
    @(posedge sysclk) disable iff (!arst_n)
    !(access.rd && access.wr)
  );

  // Peers that restart on a new address expect a single pulse
  a_addr_changed_pulse : assert property (
    @(posedge sysclk) disable iff (!arst_n)
    access.addr_changed |=> !access.addr_changed
  );

endmodule

`default_nettype wire

//--- src/dev_pkg.sv
`default_nettype none

`include "zxuno_params.svh"

package dev_pkg;

  // ------------------------------------------------------------
  // Device options register (0E)
  // ------------------------------------------------------------

  // Bit 0 at the bottom
  typedef struct packed {
    logic disable_spisd;
    logic enable_timexmmu;
    logic disable_romsel1f;
    logic disable_romsel7f;
    logic disable_1ffd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } dev_options_t;

  // ------------------------------------------------------------
  // Core identification
  // ------------------------------------------------------------

  // Index 0 is the first character streamed out
  typedef logic [0:`ZX_COREID_LEN-1][7:0] coreid_text_t;

  localparam coreid_text_t COREID_TEXT = "EXP26-01";

endpackage

`default_nettype wire

//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // ------------------------------------------------------------
  // CPU side
  // ------------------------------------------------------------

  // One Z80 bus cycle as the peripherals see it
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  dout;     // CPU write data
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
    logic [1:0]  rsvd;     // Always zero
  } io_bus_t;

  // ------------------------------------------------------------
  // Register bank side
  // ------------------------------------------------------------

  // Access to the selected register through the data port
  typedef struct packed {
    logic [7:0] addr;          // Current register number
    logic       rd;
    logic       wr;
    logic       addr_changed;  // Single cycle, after an address write
  } reg_access_t;

  // Answer of one peer on the CPU read bus
  typedef struct packed {
    logic [7:0] data;
    logic       oe;
  } rd_resp_t;

endpackage

`default_nettype wire

//--- src/zxuno_params.svh
`ifndef ZXUNO_PARAMS_SVH
`define ZXUNO_PARAMS_SVH

// ------------------------------------------------------------
// I/O ports of the register bank
// ------------------------------------------------------------

// Register number latch, read back on IN
`define ZX_PORT_REGADDR   16'hFC3B
// Data port of the selected register
`define ZX_PORT_REGDATA   16'hFD3B

// ------------------------------------------------------------
// Register numbers
// ------------------------------------------------------------

`define ZX_REG_COREID     8'hFF
`define ZX_REG_SCRATCH    8'hFE
`define ZX_REG_DEVOPTIONS 8'h0E

// ------------------------------------------------------------
// Misc
// ------------------------------------------------------------

// Characters in the core ID text
`define ZX_COREID_LEN     8

// Floating bus value, also the IM2 vector on interrupt acknowledge
`define ZX_BUS_IDLE       8'hFF

`endif
